//--- Bender.yml
package:
  name: output_pipe

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/opipe_pkg.sv
      - rtl/lane_upsizer.sv
      - rtl/word_downsizer.sv
      - rtl/packet_framer.sv
      - rtl/output_pipe.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/output_pipe_props.sv
      - test/output_pipe_tb.sv

//--- list.f
+incdir+rtl
rtl/opipe_pkg.sv
rtl/lane_upsizer.sv
rtl/word_downsizer.sv
rtl/packet_framer.sv
rtl/output_pipe.sv
test/output_pipe_props.sv
test/output_pipe_tb.sv

//--- rtl/lane_upsizer.sv
`timescale 1ns/1ps

module lane_upsizer #(
  parameter int WORDS = 4
) (
  input  logic                           aclk,
  input  logic                           arst_n,
  input  logic                           s_valid,
  output logic                           s_ready,
  input  opipe_pkg::data_t               s_data,
  output logic                           m_valid,
  input  logic                           m_ready,
  output opipe_pkg::data_t [WORDS-1:0]   m_data
);
  import opipe_pkg::*;

  localparam int CNT_W = (WORDS > 1) ? $clog2(WORDS) : 1;
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(WORDS - 1);

  data_t [WORDS-1:0] fill_q;         // row being collected
  data_t [WORDS-1:0] fill_shift;
  data_t [WORDS-1:0] buf_q;          // completed row on offer
  data_t [WORDS-1:0] buf_next;
  logic  [CNT_W-1:0] cnt_q;
  logic              fill_full_q;    // complete row parked in fill_q
  logic              buf_valid_q;
  logic              s_fire;
  logic              row_done;
  logic              buf_free;
  logic              in_to_buf;
  logic              fill_to_buf;
  logic              load_buf;

  // new word enters at the top, so the first word ends up lowest
  assign fill_shift = {s_data, fill_q[WORDS-1:1]};

  assign s_ready     = !fill_full_q;
  assign s_fire      = s_valid && s_ready;
  assign row_done    = s_fire && (cnt_q == LAST_CNT);
  assign buf_free    = !buf_valid_q || m_ready;  // empty or leaving this cycle
  assign in_to_buf   = row_done && buf_free;
  assign fill_to_buf = fill_full_q && buf_free;
  assign load_buf    = in_to_buf || fill_to_buf;
  assign buf_next    = fill_full_q ? fill_q : fill_shift;

  assign m_valid = buf_valid_q;
  assign m_data  = buf_q;

  always_ff @(posedge aclk) begin
    if (s_fire) begin
      fill_q <= fill_shift;
    end
    if (load_buf) begin
      buf_q <= buf_next;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q       <= '0;
      fill_full_q <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (s_fire) begin
        cnt_q <= row_done ? '0 : cnt_q + 1'b1;
      end

      // row finished while the buffer is still taken
      if (row_done && !buf_free) begin
        fill_full_q <= 1'b1;
      end else if (fill_to_buf) begin
        fill_full_q <= 1'b0;
      end

      if (load_buf) begin
        buf_valid_q <= 1'b1;
      end else if (buf_valid_q && m_ready) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/opipe_consts.svh
`ifndef OPIPE_CONSTS_SVH
`define OPIPE_CONSTS_SVH

// datapath sizes
`define DATA_WIDTH          8     // one core word
`define CONV_CORES          4     // core lanes per input beat
`define CONV_UNITS          4     // words per conv row per core
`define OUTPUT_DMA_WIDTH    32    // one dma word

// index of the last dma word in a packet (length - 1)
`define COUNT_1X1_REF       5     // one conv row, 6 words
`define COUNT_3X3_REF       17    // three conv rows, 18 words
`define COUNT_POOL_1X1_REF  2     // one pool block, 3 words
`define COUNT_POOL_3X3_REF  8     // three pool blocks, 9 words

`endif

//--- rtl/opipe_pkg.sv
`include "opipe_consts.svh"

package opipe_pkg;

  // one word from a single convolution core
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // one word on the output dma stream
  typedef logic [`OUTPUT_DMA_WIDTH-1:0] dma_word_t;

  // stage mode, bit 1 is maxpool and bit 0 is 3x3
  typedef enum logic [1:0] {
    MODE_CONV_1X1 = 2'b00,
    MODE_CONV_3X3 = 2'b01,
    MODE_POOL_1X1 = 2'b10,
    MODE_POOL_3X3 = 2'b11
  } opipe_mode_e;

endpackage

//--- rtl/output_pipe.sv
`timescale 1ns/1ps
`include "opipe_consts.svh"

module output_pipe (
  input  logic                                aclk,
  input  logic                                arst_n,
  input  logic                                is_maxpool,
  input  logic                                is_3x3,
  input  opipe_pkg::data_t [`CONV_CORES-1:0]  s_tdata,
  input  logic                                s_tvalid,
  output logic                                s_tready,
  output opipe_pkg::dma_word_t                m_tdata,
  output logic                                m_tvalid,
  output logic                                m_tlast,
  input  logic                                m_tready
);
  import opipe_pkg::*;

  localparam int HALF_UNITS = `CONV_UNITS / 2;
  localparam int ROW_W      = (`CONV_UNITS + 2) * `DATA_WIDTH;  // padded row
  localparam int CONV_BLK_W = `CONV_CORES * ROW_W;
  localparam int POOL_BLK_W = (`CONV_CORES / 2) * ROW_W;
  localparam int CONV_DMA_WORDS = CONV_BLK_W / `OUTPUT_DMA_WIDTH;
  localparam int POOL_DMA_WORDS = POOL_BLK_W / `OUTPUT_DMA_WIDTH;

  opipe_mode_e mode;
  logic        pool_sel;
  logic        s_fire;

  // conv path
  logic                                      conv_s_valid;
  logic      [`CONV_CORES-1:0]               conv_s_ready;
  logic      [`CONV_CORES-1:0]               conv_m_valid;
  logic                                      conv_m_ready;
  data_t     [`CONV_CORES-1:0][`CONV_UNITS-1:0] conv_rows;
  logic      [CONV_BLK_W-1:0]                conv_block;
  logic                                      conv_blk_valid;
  logic                                      conv_blk_ready;
  dma_word_t                                 conv_out_data;
  logic                                      conv_out_valid;
  logic                                      conv_out_ready;

  // pool path
  logic                                      pool_s_valid;
  logic      [`CONV_CORES-1:0]               pool_s_ready;
  logic      [`CONV_CORES-1:0]               pool_m_valid;
  logic                                      pool_m_ready;
  data_t     [`CONV_CORES-1:0][HALF_UNITS-1:0] pool_rows;
  logic      [POOL_BLK_W-1:0]                pool_block;
  logic                                      pool_blk_valid;
  logic                                      pool_blk_ready;
  dma_word_t                                 pool_out_data;
  logic                                      pool_out_valid;
  logic                                      pool_out_ready;

  always_comb begin
    case ({is_maxpool, is_3x3})
      2'b00:   mode = MODE_CONV_1X1;
      2'b01:   mode = MODE_CONV_3X3;
      2'b10:   mode = MODE_POOL_1X1;
      default: mode = MODE_POOL_3X3;
    endcase
  end

  assign pool_sel = (mode == MODE_POOL_1X1) || (mode == MODE_POOL_3X3);

  // all lanes of the active path take the beat together
  assign s_tready     = pool_sel ? &pool_s_ready : &conv_s_ready;
  assign s_fire       = s_tvalid && s_tready;
  assign conv_s_valid = s_fire && !pool_sel;
  assign pool_s_valid = s_fire && pool_sel;

  genvar i;
  generate
    for (i = 0; i < `CONV_CORES; i++) begin : g_lane
      lane_upsizer #(
        .WORDS (`CONV_UNITS)
      ) u_conv_lane (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .s_valid (conv_s_valid),
        .s_ready (conv_s_ready[i]),
        .s_data  (s_tdata[i]),
        .m_valid (conv_m_valid[i]),
        .m_ready (conv_m_ready),
        .m_data  (conv_rows[i])
      );

      lane_upsizer #(
        .WORDS (HALF_UNITS)
      ) u_pool_lane (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .s_valid (pool_s_valid),
        .s_ready (pool_s_ready[i]),
        .s_data  (s_tdata[i]),
        .m_valid (pool_m_valid[i]),
        .m_ready (pool_m_ready),
        .m_data  (pool_rows[i])
      );

      // zero word on both ends of each core row
      assign conv_block[i*ROW_W +: ROW_W] =
        {{`DATA_WIDTH{1'b0}}, conv_rows[i], {`DATA_WIDTH{1'b0}}};
    end

    // cores 2p and 2p+1 share one pool row
    for (i = 0; i < `CONV_CORES / 2; i++) begin : g_pair
      assign pool_block[i*ROW_W +: ROW_W] =
        {{`DATA_WIDTH{1'b0}}, pool_rows[2*i+1], pool_rows[2*i], {`DATA_WIDTH{1'b0}}};
    end
  endgenerate

  // block is complete only when every lane holds its row
  assign conv_blk_valid = &conv_m_valid && !pool_sel;
  assign conv_m_ready   = conv_blk_ready && conv_blk_valid;
  assign pool_blk_valid = &pool_m_valid && pool_sel;
  assign pool_m_ready   = pool_blk_ready && pool_blk_valid;

  word_downsizer #(
    .IN_WORDS (CONV_DMA_WORDS)
  ) u_conv_down (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (conv_blk_valid),
    .s_ready (conv_blk_ready),
    .s_data  (conv_block),
    .m_valid (conv_out_valid),
    .m_ready (conv_out_ready),
    .m_data  (conv_out_data)
  );

  word_downsizer #(
    .IN_WORDS (POOL_DMA_WORDS)
  ) u_pool_down (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (pool_blk_valid),
    .s_ready (pool_blk_ready),
    .s_data  (pool_block),
    .m_valid (pool_out_valid),
    .m_ready (pool_out_ready),
    .m_data  (pool_out_data)
  );

  assign conv_out_ready = m_tready && !pool_sel;
  assign pool_out_ready = m_tready && pool_sel;
  assign m_tdata        = pool_sel ? pool_out_data : conv_out_data;
  assign m_tvalid       = pool_sel ? pool_out_valid : conv_out_valid;

  packet_framer u_framer (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .mode     (mode),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast)
  );

endmodule

//--- rtl/packet_framer.sv
`timescale 1ns/1ps
`include "opipe_consts.svh"

module packet_framer (
  input  logic                     aclk,
  input  logic                     arst_n,
  input  opipe_pkg::opipe_mode_e   mode,
  input  logic                     m_tvalid,
  input  logic                     m_tready,
  output logic                     m_tlast
);
  import opipe_pkg::*;

  // sized for the longest packet
  localparam int CNT_W = $clog2(`COUNT_3X3_REF + 1);

  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_ref;
  logic             count_equal;
  logic             m_fire;

  always_comb begin
    case (mode)
      MODE_CONV_1X1: count_ref = CNT_W'(`COUNT_1X1_REF);
      MODE_CONV_3X3: count_ref = CNT_W'(`COUNT_3X3_REF);
      MODE_POOL_1X1: count_ref = CNT_W'(`COUNT_POOL_1X1_REF);
      MODE_POOL_3X3: count_ref = CNT_W'(`COUNT_POOL_3X3_REF);
      default:       count_ref = CNT_W'(`COUNT_1X1_REF);
    endcase
  end

  assign count_equal = (count_q == count_ref);
  assign m_fire      = m_tvalid && m_tready;
  assign m_tlast     = m_tvalid && count_equal;

  // counts dma handshakes within the packet
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else if (m_fire) begin
      if (count_equal) begin
        count_q <= '0;     // packet done
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

endmodule

//--- rtl/word_downsizer.sv
`timescale 1ns/1ps

module word_downsizer #(
  parameter int IN_WORDS = 6
) (
  input  logic                                 aclk,
  input  logic                                 arst_n,
  input  logic                                 s_valid,
  output logic                                 s_ready,
  input  opipe_pkg::dma_word_t [IN_WORDS-1:0]  s_data,
  output logic                                 m_valid,
  input  logic                                 m_ready,
  output opipe_pkg::dma_word_t                 m_data
);
  import opipe_pkg::*;

  localparam int IDX_W = (IN_WORDS > 1) ? $clog2(IN_WORDS) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(IN_WORDS - 1);

  dma_word_t [IN_WORDS-1:0] block_q;   // block being sliced
  logic      [IDX_W-1:0]    idx_q;     // next word to send
  logic                     valid_q;
  logic                     m_fire;
  logic                     last_word;
  logic                     load;

  assign m_fire    = valid_q && m_ready;
  assign last_word = (idx_q == LAST_IDX);

  // take a new block when empty or when the final word goes out
  assign s_ready = !valid_q || (m_ready && last_word);
  assign load    = s_valid && s_ready;

  assign m_valid = valid_q;
  assign m_data  = block_q[idx_q];   // lowest unsent word

  always_ff @(posedge aclk) begin
    if (load) begin
      block_q <= s_data;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      idx_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      if (load) begin
        idx_q   <= '0;
        valid_q <= 1'b1;
      end else if (m_fire) begin
        if (last_word) begin
          idx_q   <= '0;
          valid_q <= 1'b0;  // nothing waiting, go empty
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

endmodule

//--- test/output_pipe_props.sv
`timescale 1ns/1ps

module output_pipe_props (
  input logic                  aclk,
  input logic                  arst_n,
  input opipe_pkg::dma_word_t  m_tdata,
  input logic                  m_tvalid,
  input logic                  m_tlast,
  input logic                  m_tready
);

  // tlast only qualifies a valid word
  tlast_needs_valid: assert property (
    @(posedge aclk) disable iff (!arst_n)
    m_tlast |-> m_tvalid
  ) else $error("m_tlast high while m_tvalid is low");

  // stalled word must not change
  hold_on_stall: assert property (
    @(posedge aclk) disable iff (!arst_n)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata))
  ) else $error("m_tdata or m_tvalid changed while stalled");

  valid_low_after_reset: assert property (
    @(posedge aclk)
    $rose(arst_n) |-> !m_tvalid
  ) else $error("m_tvalid high in the first cycle after reset");

endmodule

bind output_pipe output_pipe_props u_props (
  .aclk     (aclk),
  .arst_n   (arst_n),
  .m_tdata  (m_tdata),
  .m_tvalid (m_tvalid),
  .m_tlast  (m_tlast),
  .m_tready (m_tready)
);

//--- test/output_pipe_tb.sv
`timescale 1ns/1ps
`include "opipe_consts.svh"

module output_pipe_tb;
  import opipe_pkg::*;

  localparam int PACKETS       = 4;   // complete packets per mode
  localparam int BYTES_PER_DMA = `OUTPUT_DMA_WIDTH / `DATA_WIDTH;
  localparam int CONV_BLK_WORDS =
    `CONV_CORES * (`CONV_UNITS + 2) * `DATA_WIDTH / `OUTPUT_DMA_WIDTH;
  localparam int POOL_BLK_WORDS =
    (`CONV_CORES / 2) * (`CONV_UNITS + 2) * `DATA_WIDTH / `OUTPUT_DMA_WIDTH;
  localparam int CONV_1X1_BEATS = PACKETS * ((`COUNT_1X1_REF + 1) / CONV_BLK_WORDS) * `CONV_UNITS;
  localparam int CONV_3X3_BEATS = PACKETS * ((`COUNT_3X3_REF + 1) / CONV_BLK_WORDS) * `CONV_UNITS;
  localparam int POOL_1X1_BEATS =
    PACKETS * ((`COUNT_POOL_1X1_REF + 1) / POOL_BLK_WORDS) * (`CONV_UNITS / 2);
  localparam int POOL_3X3_BEATS =
    PACKETS * ((`COUNT_POOL_3X3_REF + 1) / POOL_BLK_WORDS) * (`CONV_UNITS / 2);
  localparam int TOTAL_BEATS    =
    CONV_1X1_BEATS + CONV_3X3_BEATS + POOL_1X1_BEATS + POOL_3X3_BEATS;
  localparam int TIMEOUT_CYCLES = 8 * TOTAL_BEATS + 1000;

  logic                       aclk;
  logic                       arst_n;
  logic                       is_maxpool;
  logic                       is_3x3;
  data_t [`CONV_CORES-1:0]    s_tdata;
  logic                       s_tvalid;
  logic                       s_tready;
  dma_word_t                  m_tdata;
  logic                       m_tvalid;
  logic                       m_tlast;
  logic                       m_tready;

  // reference model state
  data_t [`CONV_CORES-1:0]    beat_q [$];      // accepted beats of the open block
  dma_word_t                  exp_data_q [$];
  logic                       exp_last_q [$];
  logic                       cur_pool;
  int                         cur_ref;
  int                         out_idx;         // word position inside the packet
  int                         word_cnt;
  int                         cycle_cnt;

  output_pipe UUT (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .is_maxpool (is_maxpool),
    .is_3x3     (is_3x3),
    .s_tdata    (s_tdata),
    .s_tvalid   (s_tvalid),
    .s_tready   (s_tready),
    .m_tdata    (m_tdata),
    .m_tvalid   (m_tvalid),
    .m_tlast    (m_tlast),
    .m_tready   (m_tready)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  task automatic check_word(input dma_word_t got, input dma_word_t exp);
    if (got !== exp) begin
      $display("error %0t: word %0d m_tdata is %h, expected %h", $time, word_cnt, got, exp);
      $display("TEST FAILED");
      $fatal(1, "output data mismatch");
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %0t: word %0d m_tlast is %b, expected %b", $time, word_cnt, got, exp);
      $display("TEST FAILED");
      $fatal(1, "tlast mismatch");
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "control flag mismatch");
    end
  endtask

  // slices a byte row into dma words, lowest byte first
  task automatic emit_words(input data_t row_bytes [$]);
    dma_word_t w;
    for (int k = 0; k < row_bytes.size() / BYTES_PER_DMA; k++) begin
      for (int b = 0; b < BYTES_PER_DMA; b++) begin
        w[b*`DATA_WIDTH +: `DATA_WIDTH] = row_bytes[k*BYTES_PER_DMA + b];
      end
      exp_data_q.push_back(w);
      exp_last_q.push_back(out_idx == cur_ref);
      out_idx = (out_idx == cur_ref) ? 0 : out_idx + 1;
    end
  endtask

  // zero, units of core c in arrival order, zero
  task automatic build_conv_block();
    data_t row_bytes [$];
    for (int c = 0; c < `CONV_CORES; c++) begin
      row_bytes.push_back('0);
      for (int u = 0; u < `CONV_UNITS; u++) begin
        row_bytes.push_back(beat_q[u][c]);
      end
      row_bytes.push_back('0);
    end
    beat_q.delete();
    emit_words(row_bytes);
  endtask

  // cores 2p and 2p+1 joined into one padded row
  task automatic build_pool_block();
    data_t row_bytes [$];
    for (int p = 0; p < `CONV_CORES / 2; p++) begin
      row_bytes.push_back('0);
      for (int c = 2 * p; c <= 2 * p + 1; c++) begin
        for (int u = 0; u < `CONV_UNITS / 2; u++) begin
          row_bytes.push_back(beat_q[u][c]);
        end
      end
      row_bytes.push_back('0);
    end
    beat_q.delete();
    emit_words(row_bytes);
  endtask

  task automatic collect_beat(input data_t [`CONV_CORES-1:0] beat);
    beat_q.push_back(beat);
    if (!cur_pool && beat_q.size() == `CONV_UNITS) begin
      build_conv_block();
    end else if (cur_pool && beat_q.size() == `CONV_UNITS / 2) begin
      build_pool_block();
    end
  endtask

  // sends a number of beats in one mode, then waits for the stage to drain
  task automatic run_mode(input logic pool, input logic three, input int ref_idx,
                          input int beats);
    int   sent;
    logic accepted;
    sent       = 0;
    is_maxpool = pool;
    is_3x3     = three;
    cur_pool   = pool;
    cur_ref    = ref_idx;
    out_idx    = 0;
    while (sent < beats) begin
      @(posedge aclk);
      accepted = s_tvalid && s_tready;
      #1;
      m_tready = ($urandom % 100) < 60;
      if (accepted) begin
        sent++;
      end
      if (!s_tvalid || accepted) begin  // otherwise hold the beat
        if (sent < beats && ($urandom % 100) < 70) begin
          s_tvalid = 1'b1;
          for (int c = 0; c < `CONV_CORES; c++) begin
            s_tdata[c] = data_t'($urandom);
          end
        end else begin
          s_tvalid = 1'b0;
        end
      end
    end
    while (exp_data_q.size() != 0) begin
      @(posedge aclk);
      #1;
      m_tready = ($urandom % 100) < 60;
    end
  endtask

  // scoreboard, samples on the rising edge
  always @(posedge aclk) begin
    if (arst_n) begin
      if (s_tvalid && s_tready) begin
        collect_beat(s_tdata);
      end
      if (m_tvalid && m_tready) begin
        if (exp_data_q.size() == 0) begin
          $display("error %0t: output word %h with nothing expected", $time, m_tdata);
          $display("TEST FAILED");
          $fatal(1, "unexpected output word");
        end
        check_word(m_tdata, exp_data_q.pop_front());
        check_last(m_tlast, exp_last_q.pop_front());
        word_cnt++;
      end
    end
  end

  always @(posedge aclk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    void'($urandom(32'h15266bb0));
    arst_n     = 1'b0;
    is_maxpool = 1'b0;
    is_3x3     = 1'b0;
    s_tdata    = '0;
    s_tvalid   = 1'b0;
    m_tready   = 1'b0;
    cur_pool   = 1'b0;
    cur_ref    = `COUNT_1X1_REF;
    out_idx    = 0;
    word_cnt   = 0;
    cycle_cnt  = 0;
    repeat (5) @(posedge aclk);
    #1 arst_n = 1'b1;
    @(posedge aclk);
    check_flag("m_tvalid after reset", m_tvalid, 1'b0);
    check_last(m_tlast, 1'b0);
    check_flag("s_tready after reset", s_tready, 1'b1);
    #1;
    run_mode(1'b0, 1'b0, `COUNT_1X1_REF, CONV_1X1_BEATS);
    run_mode(1'b0, 1'b1, `COUNT_3X3_REF, CONV_3X3_BEATS);
    run_mode(1'b1, 1'b0, `COUNT_POOL_1X1_REF, POOL_1X1_BEATS);
    run_mode(1'b1, 1'b1, `COUNT_POOL_3X3_REF, POOL_3X3_BEATS);
    m_tready = 1'b1;                 // let any stray word reach the scoreboard
    repeat (4) @(posedge aclk);
    #1;
    if (!m_tvalid && s_tready) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("stage not empty at the end, m_tvalid %b s_tready %b", m_tvalid, s_tready);
      $display("TEST FAILED");
      $fatal(1, "stage not empty at the end of the run");
    end
  end

endmodule
